//--- logic/l2_cache_params.svh
/*
 * Size constants for the four-way L2 cache. Every RTL file includes this
 * header; the package builds its types from these widths.
 */
`ifndef L2_CACHE_PARAMS_SVH
`define L2_CACHE_PARAMS_SVH

`define L2_ADDR_W   32  // request byte address
`define L2_WORD_W   128 // one request word
`define L2_LINE_W   512 // four words per line
`define L2_WAYS     4   // fixed by the 3-bit plru tree
`define L2_INDEX_W  9   // 512 sets
`define L2_WSEL_W   2   // word within line
`define L2_BYTE_W   4   // byte offset, ignored

// tag takes whatever is left above index, word select and byte offset
`define L2_TAG_W    (`L2_ADDR_W - `L2_INDEX_W - `L2_WSEL_W - `L2_BYTE_W)

// memory works in whole lines, addressed by tag then index
`define L2_LADDR_W  (`L2_TAG_W + `L2_INDEX_W)

`endif

//--- logic/l2_cache_pkg.sv
/*
 * Shared types of the L2 cache and the controller state encoding.
 * Referenced by scoped name from the RTL and the testbench.
 */
`include "l2_cache_params.svh"

package l2_cache_pkg;

    typedef logic [`L2_ADDR_W-1:0]        addr_t;
    typedef logic [`L2_WORD_W-1:0]        word_t;
    typedef logic [`L2_LINE_W-1:0]        line_t;
    typedef logic [`L2_TAG_W-1:0]         tag_t;
    typedef logic [`L2_INDEX_W-1:0]       index_t;
    typedef logic [`L2_WSEL_W-1:0]        wsel_t;
    typedef logic [$clog2(`L2_WAYS)-1:0]  way_t;
    typedef logic [`L2_WAYS-1:0]          way_mask_t;
    typedef logic [`L2_LADDR_W-1:0]       line_addr_t; // {tag, index}

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,  // dirty victim going out
        REFILL      // waiting for the requested line
    } l2_state_t;

endpackage

//--- logic/l2_set_ram.sv
/*
 * Per-set storage with one entry per way, used for both tags and lines.
 * Write is on the clock edge, the read of the addressed set is combinational.
 */
`timescale 1ns/10ps
`include "l2_cache_params.svh"

module l2_set_ram #(
    parameter type entry_t = logic [7:0],
    parameter bit  CLEAR   = 1'b0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  l2_cache_pkg::index_t  index,
    input  logic                  we,
    input  l2_cache_pkg::way_t    way,
    input  entry_t                wd,
    output entry_t                rd [`L2_WAYS]
);

    localparam int SETS = 1 << `L2_INDEX_W;

    entry_t mem [SETS][`L2_WAYS];

    always_ff @(posedge clk) begin
        if (CLEAR && rst) begin // only the tag store clears
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < `L2_WAYS; w++) begin
                    mem[s][w] <= '0;
                end
            end
        end else if (we) begin
            mem[index][way] <= wd;
        end
    end

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            rd[w] = mem[index][w];
        end
    end

    assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(way))
        else $error("set ram write with unknown way");

endmodule

//--- logic/l2_tag_lookup.sv
/*
 * Tag store and four-way compare. Reports the lowest matching valid way,
 * plus the valid mask and raw entries for victim handling.
 */
`timescale 1ns/10ps
`include "l2_cache_params.svh"

module l2_tag_lookup (
    input  logic                       clk,
    input  logic                       rst,
    input  l2_cache_pkg::index_t       index,
    input  l2_cache_pkg::tag_t         tag,
    input  logic                       tag_we,
    input  l2_cache_pkg::way_t         tag_way,
    input  l2_cache_pkg::tag_entry_t   tag_wd,
    output logic                       hit,
    output l2_cache_pkg::way_t         hit_way,
    output l2_cache_pkg::way_mask_t    valid_ways,
    output l2_cache_pkg::tag_entry_t   entries [`L2_WAYS]
);

    logic [`L2_WAYS-1:0] match;
    logic                dup;

    l2_set_ram #(
        .entry_t (l2_cache_pkg::tag_entry_t),
        .CLEAR   (1'b1)
    ) tag_ram_i (
        .clk   (clk),
        .rst   (rst),
        .index (index),
        .we    (tag_we),
        .way   (tag_way),
        .wd    (tag_wd),
        .rd    (entries)
    );

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            valid_ways[w] = entries[w].valid;
            match[w]      = entries[w].valid && (entries[w].tag == tag);
        end
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin // lowest way wins
            if (match[w]) begin
                hit_way = l2_cache_pkg::way_t'(w);
            end
        end
        hit = |match;
    end

    // a line is only ever allocated on a miss, so a tag lives in one way
    always_comb begin
        dup = 1'b0;
        for (int i = 0; i < `L2_WAYS; i++) begin
            for (int j = i + 1; j < `L2_WAYS; j++) begin
                if (entries[i].valid && entries[j].valid &&
                    entries[i].tag == entries[j].tag) begin
                    dup = 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !dup)
        else $error("same tag valid in two ways of set %0d", index);

endmodule

//--- logic/l2_replace.sv
/*
 * Replacement state, three tree bits per set. Picks the lowest invalid way
 * first, otherwise follows the tree; each completed access re-points it.
 */
`timescale 1ns/10ps
`include "l2_cache_params.svh"

module l2_replace (
    input  logic                     clk,
    input  logic                     rst,
    input  l2_cache_pkg::index_t     index,
    input  l2_cache_pkg::way_mask_t  valid_ways,
    input  logic                     touch,
    input  l2_cache_pkg::way_t       touch_way,
    output l2_cache_pkg::way_t       victim_way
);

    localparam int SETS = 1 << `L2_INDEX_W;

    logic [2:0] tree [SETS]; // [0] picks half, [1] ways 0/1, [2] ways 2/3
    logic [2:0] cur;

    assign cur = tree[index];

    always_comb begin
        victim_way = '0;
        if (&valid_ways) begin
            if (!cur[0]) begin
                victim_way = cur[1] ? 2'd1 : 2'd0;
            end else begin
                victim_way = cur[2] ? 2'd3 : 2'd2;
            end
        end else begin
            for (int w = `L2_WAYS - 1; w >= 0; w--) begin // lowest invalid
                if (!valid_ways[w]) begin
                    victim_way = l2_cache_pkg::way_t'(w);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= 3'b000;
            end
        end else if (touch) begin
            case (touch_way) // point away from the touched way
                2'd0: begin
                    tree[index][0] <= 1'b1;
                    tree[index][1] <= 1'b1;
                end
                2'd1: begin
                    tree[index][0] <= 1'b1;
                    tree[index][1] <= 1'b0;
                end
                2'd2: begin
                    tree[index][0] <= 1'b0;
                    tree[index][2] <= 1'b1;
                end
                default: begin
                    tree[index][0] <= 1'b0;
                    tree[index][2] <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- logic/l2_cache_ctrl.sv
/*
 * Request FSM of the L2 cache. Holds the request, merges lookup and victim
 * results, selects or merges the word, and runs writeback and refill.
 */
`timescale 1ns/10ps
`include "l2_cache_params.svh"

module l2_cache_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  logic                      we,
    input  l2_cache_pkg::addr_t       addr,
    input  l2_cache_pkg::word_t       wdata,
    input  logic                      hit,
    input  l2_cache_pkg::way_t        hit_way,
    input  l2_cache_pkg::tag_entry_t  entries [`L2_WAYS],
    input  l2_cache_pkg::way_t        victim_way,
    input  l2_cache_pkg::line_t       lines [`L2_WAYS],
    input  logic                      mem_ack,
    input  l2_cache_pkg::line_t       mem_rd,
    output logic                      busy,
    output logic                      done,
    output l2_cache_pkg::word_t       rdata,
    output l2_cache_pkg::index_t      index,
    output l2_cache_pkg::tag_t        tag,
    output logic                      tag_we,
    output l2_cache_pkg::way_t        tag_way,
    output l2_cache_pkg::tag_entry_t  tag_wd,
    output logic                      touch,
    output l2_cache_pkg::way_t        touch_way,
    output logic                      data_we,
    output l2_cache_pkg::way_t        data_way,
    output l2_cache_pkg::line_t       data_wd,
    output logic                      mem_req,
    output logic                      mem_we,
    output l2_cache_pkg::line_addr_t  mem_addr,
    output l2_cache_pkg::line_t       mem_wd
);

    l2_cache_pkg::l2_state_t  state;
    logic                     we_q;
    l2_cache_pkg::wsel_t      wsel_q;
    l2_cache_pkg::word_t      wdata_q;
    l2_cache_pkg::way_t       victim_q;  // held across writeback/refill
    l2_cache_pkg::tag_entry_t vict_entry;
    l2_cache_pkg::line_t      hit_line;
    l2_cache_pkg::line_t      merged;
    logic                     vict_dirty;
    logic                     lookup_hit;
    logic                     refill_done;

    assign busy        = (state != l2_cache_pkg::IDLE);
    assign lookup_hit  = (state == l2_cache_pkg::LOOKUP) && hit;
    assign refill_done = (state == l2_cache_pkg::REFILL) && mem_ack;
    assign done        = lookup_hit;
    assign vict_entry  = entries[victim_way];
    assign vict_dirty  = vict_entry.valid && vict_entry.dirty;

    // word select and write merge on the hit line
    assign hit_line = lines[hit_way];
    assign rdata    = hit_line[wsel_q * `L2_WORD_W +: `L2_WORD_W];

    always_comb begin
        merged = hit_line;
        merged[wsel_q * `L2_WORD_W +: `L2_WORD_W] = wdata_q;
    end

    // store writes: write hit or refill, never both
    assign tag_we    = (lookup_hit && we_q) || refill_done;
    assign data_we   = tag_we;
    assign tag_way   = refill_done ? victim_q : hit_way;
    assign data_way  = tag_way;
    assign data_wd   = refill_done ? mem_rd : merged;
    assign touch     = lookup_hit;
    assign touch_way = hit_way;

    always_comb begin
        tag_wd.valid = 1'b1;
        tag_wd.dirty = !refill_done; // refilled lines start clean
        tag_wd.tag   = tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= l2_cache_pkg::IDLE;
            we_q    <= 1'b0;
            tag     <= '0;
            index   <= '0;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            mem_req <= 1'b0; // strobe
            case (state)
                l2_cache_pkg::IDLE: begin
                    if (req) begin
                        we_q  <= we;
                        tag   <= addr[`L2_ADDR_W-1 -: `L2_TAG_W];
                        index <= addr[`L2_BYTE_W + `L2_WSEL_W +: `L2_INDEX_W];
                        state <= l2_cache_pkg::LOOKUP;
                    end
                end
                l2_cache_pkg::LOOKUP: begin
                    if (hit) begin
                        state <= l2_cache_pkg::IDLE;
                    end else begin
                        mem_req <= 1'b1;
                        mem_we  <= vict_dirty;
                        state   <= vict_dirty ? l2_cache_pkg::WRITEBACK
                                              : l2_cache_pkg::REFILL;
                    end
                end
                l2_cache_pkg::WRITEBACK: begin
                    if (mem_ack) begin // victim out, fetch the new line
                        mem_req <= 1'b1;
                        mem_we  <= 1'b0;
                        state   <= l2_cache_pkg::REFILL;
                    end
                end
                default: begin
                    if (mem_ack) begin
                        state <= l2_cache_pkg::LOOKUP; // replay, now hits
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == l2_cache_pkg::IDLE && req) begin
            wsel_q  <= addr[`L2_BYTE_W +: `L2_WSEL_W];
            wdata_q <= wdata;
        end
        if (state == l2_cache_pkg::LOOKUP && !hit) begin
            victim_q <= victim_way;
            mem_wd   <= lines[victim_way];
            mem_addr <= vict_dirty ? {vict_entry.tag, index} : {tag, index};
        end
        if (state == l2_cache_pkg::WRITEBACK && mem_ack) begin
            mem_addr <= {tag, index};
        end
    end

    assert property (@(posedge clk) disable iff (rst) req |-> !busy)
        else $error("req while busy");

    assert property (@(posedge clk) disable iff (rst)
        mem_ack |-> (state == l2_cache_pkg::WRITEBACK || state == l2_cache_pkg::REFILL))
        else $error("mem_ack with no memory request pending");

endmodule

//--- logic/l2_cache.sv
/*
 * Top level of the four-way write-back L2 cache. Lookup and replacement
 * run side by side on the request index; the controller combines them.
 */
`timescale 1ns/10ps
`include "l2_cache_params.svh"

module l2_cache (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  logic                      we,
    input  l2_cache_pkg::addr_t       addr,
    input  l2_cache_pkg::word_t       wdata,
    output logic                      busy,
    output logic                      done,
    output l2_cache_pkg::word_t       rdata,
    output logic                      mem_req,
    output logic                      mem_we,
    output l2_cache_pkg::line_addr_t  mem_addr,
    output l2_cache_pkg::line_t       mem_wd,
    input  logic                      mem_ack,
    input  l2_cache_pkg::line_t       mem_rd
);

    l2_cache_pkg::index_t       index;
    l2_cache_pkg::tag_t         tag;
    logic                       hit;
    l2_cache_pkg::way_t         hit_way;
    l2_cache_pkg::way_mask_t    valid_ways;
    l2_cache_pkg::tag_entry_t   entries [`L2_WAYS];
    l2_cache_pkg::way_t         victim_way;
    logic                       tag_we;
    l2_cache_pkg::way_t         tag_way;
    l2_cache_pkg::tag_entry_t   tag_wd;
    logic                       touch;
    l2_cache_pkg::way_t         touch_way;
    logic                       data_we;
    l2_cache_pkg::way_t         data_way;
    l2_cache_pkg::line_t        data_wd;
    l2_cache_pkg::line_t        lines [`L2_WAYS];

    l2_tag_lookup tag_lookup_i (
        .clk (clk), .rst (rst), .index (index), .tag (tag),
        .tag_we (tag_we), .tag_way (tag_way), .tag_wd (tag_wd),
        .hit (hit), .hit_way (hit_way), .valid_ways (valid_ways), .entries (entries)
    );

    l2_replace replace_i (
        .clk (clk), .rst (rst), .index (index), .valid_ways (valid_ways),
        .touch (touch), .touch_way (touch_way), .victim_way (victim_way)
    );

    l2_set_ram #(
        .entry_t (l2_cache_pkg::line_t),
        .CLEAR   (1'b0)
    ) data_ram_i (
        .clk (clk), .rst (rst), .index (index), .we (data_we),
        .way (data_way), .wd (data_wd), .rd (lines)
    );

    l2_cache_ctrl ctrl_i (
        .clk (clk), .rst (rst), .req (req), .we (we), .addr (addr), .wdata (wdata),
        .hit (hit), .hit_way (hit_way), .entries (entries), .victim_way (victim_way),
        .lines (lines), .mem_ack (mem_ack), .mem_rd (mem_rd),
        .busy (busy), .done (done), .rdata (rdata), .index (index), .tag (tag),
        .tag_we (tag_we), .tag_way (tag_way), .tag_wd (tag_wd),
        .touch (touch), .touch_way (touch_way),
        .data_we (data_we), .data_way (data_way), .data_wd (data_wd),
        .mem_req (mem_req), .mem_we (mem_we), .mem_addr (mem_addr), .mem_wd (mem_wd)
    );

endmodule

//--- tests/l2_cache_tb.sv
/*
 * Table-driven testbench for the L2 cache, with a behavioral line memory
 * and a reference model of tags, dirty bits and tree state.
 */
`timescale 1ns/10ps
`include "l2_cache_params.svh"

module l2_cache_tb;

    localparam int SETS        = 1 << `L2_INDEX_W;
    localparam int N_FIXED     = 19;
    localparam int N_RANDOM    = 40;
    localparam int N_ENTRIES   = N_FIXED + N_RANDOM;
    localparam int CYCLE_LIMIT = N_ENTRIES * 20 + 50;
    localparam int EXP_ANY     = 0; // kind decided by the reference model only
    localparam int EXP_HIT     = 1;
    localparam int EXP_MISS    = 2; // clean or invalid victim
    localparam int EXP_DIRTY   = 3; // writeback before the refill
    localparam l2_cache_pkg::index_t SET_A = 9'h01a;
    localparam l2_cache_pkg::index_t SET_B = 9'h155;
    localparam l2_cache_pkg::word_t  WORD_X = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;

    logic                     clk;
    logic                     rst;
    logic                     req;
    logic                     we;
    l2_cache_pkg::addr_t      addr;
    l2_cache_pkg::word_t      wdata;
    logic                     busy;
    logic                     done;
    l2_cache_pkg::word_t      rdata;
    logic                     mem_req;
    logic                     mem_we;
    l2_cache_pkg::line_addr_t mem_addr;
    l2_cache_pkg::line_t      mem_wd;
    logic                     mem_ack;
    l2_cache_pkg::line_t      mem_rd;

    logic                     tbl_we    [N_ENTRIES];
    l2_cache_pkg::addr_t      tbl_addr  [N_ENTRIES];
    l2_cache_pkg::word_t      tbl_wdata [N_ENTRIES];
    int                       tbl_exp   [N_ENTRIES];
    int                       n_fill;

    logic                     ref_valid [SETS][`L2_WAYS];
    logic                     ref_dirty [SETS][`L2_WAYS];
    l2_cache_pkg::tag_t       ref_tag   [SETS][`L2_WAYS];
    l2_cache_pkg::line_t      ref_line  [SETS][`L2_WAYS];
    logic [2:0]               ref_tree  [SETS];

    l2_cache_pkg::line_t      mem_store [l2_cache_pkg::line_addr_t];
    logic                     log_we   [$];
    l2_cache_pkg::line_addr_t log_addr [$];
    l2_cache_pkg::line_t      log_data [$];
    logic                     mem_pending;
    int                       mem_wait;
    l2_cache_pkg::line_addr_t mem_pend_addr;

    integer                   seed;
    int                       cycle_count;

    l2_cache dut_i (
        .clk (clk), .rst (rst), .req (req), .we (we), .addr (addr), .wdata (wdata),
        .busy (busy), .done (done), .rdata (rdata),
        .mem_req (mem_req), .mem_we (mem_we), .mem_addr (mem_addr), .mem_wd (mem_wd),
        .mem_ack (mem_ack), .mem_rd (mem_rd)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input l2_cache_pkg::word_t got,
                              input l2_cache_pkg::word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            stop_with_failure("word compare failed");
        end
    endtask

    task automatic check_line(input string name, input l2_cache_pkg::line_t got,
                              input l2_cache_pkg::line_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            stop_with_failure("line compare failed");
        end
    endtask

    task automatic check_addr(input string name, input l2_cache_pkg::line_addr_t got,
                              input l2_cache_pkg::line_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            stop_with_failure("line address compare failed");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            stop_with_failure("flag compare failed");
        end
    endtask

    // untouched memory mixes the line address and the word position
    function automatic l2_cache_pkg::line_t pattern_line(input l2_cache_pkg::line_addr_t a);
        l2_cache_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*`L2_WORD_W +: `L2_WORD_W] = {6'd0, a, 32'hface_0000 + 32'(w),
                                             ~{6'd0, a}, 32'h1234_0000 + 32'(w)};
        end
        return l;
    endfunction

    function automatic l2_cache_pkg::line_t read_mem(input l2_cache_pkg::line_addr_t a);
        if (mem_store.exists(a)) begin
            return mem_store[a];
        end
        return pattern_line(a);
    endfunction

    function automatic l2_cache_pkg::way_t pick_victim(input l2_cache_pkg::index_t idx);
        l2_cache_pkg::way_t v;
        logic [2:0]         t;
        t = ref_tree[idx];
        if (!t[0]) begin
            v = t[1] ? 2'd1 : 2'd0;
        end else begin
            v = t[2] ? 2'd3 : 2'd2;
        end
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin // any invalid way goes first
            if (!ref_valid[idx][w]) begin
                v = l2_cache_pkg::way_t'(w);
            end
        end
        return v;
    endfunction

    task automatic touch_tree(input l2_cache_pkg::index_t idx, input l2_cache_pkg::way_t way);
        case (way)
            2'd0: ref_tree[idx] = {ref_tree[idx][2], 2'b11};
            2'd1: ref_tree[idx] = {ref_tree[idx][2], 2'b01};
            2'd2: ref_tree[idx] = {1'b1, ref_tree[idx][1], 1'b0};
            default: ref_tree[idx] = {1'b0, ref_tree[idx][1], 1'b0};
        endcase
    endtask

    task automatic add_entry(input logic wr, input l2_cache_pkg::tag_t tg,
                             input l2_cache_pkg::index_t idx, input l2_cache_pkg::wsel_t ws,
                             input l2_cache_pkg::word_t d, input int exp);
        tbl_we[n_fill]    = wr;
        tbl_addr[n_fill]  = {tg, idx, ws, 4'h0};
        tbl_wdata[n_fill] = d;
        tbl_exp[n_fill]   = exp;
        n_fill++;
    endtask

    task automatic run_entry(input int i);
        l2_cache_pkg::tag_t   tg;
        l2_cache_pkg::index_t idx;
        l2_cache_pkg::wsel_t  ws;
        l2_cache_pkg::way_t   way;
        l2_cache_pkg::word_t  got;
        logic                 is_hit;
        logic                 wb;
        int                   seen;
        int                   n_exp;
        int                   waited;
        tg     = tbl_addr[i][`L2_ADDR_W-1 -: `L2_TAG_W];
        idx    = tbl_addr[i][`L2_BYTE_W + `L2_WSEL_W +: `L2_INDEX_W];
        ws     = tbl_addr[i][`L2_BYTE_W +: `L2_WSEL_W];
        is_hit = 1'b0;
        way    = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tg) begin
                is_hit = 1'b1;
                way    = l2_cache_pkg::way_t'(w);
            end
        end
        if (!is_hit) begin
            way = pick_victim(idx);
        end
        wb    = !is_hit && ref_valid[idx][way] && ref_dirty[idx][way];
        n_exp = is_hit ? 0 : (wb ? 2 : 1);
        log_we.delete();
        log_addr.delete();
        log_data.delete();
        req   <= 1'b1;
        we    <= tbl_we[i];
        addr  <= tbl_addr[i];
        wdata <= tbl_wdata[i];
        @(posedge clk);
        check_flag("busy", busy, 1'b0); // idle while req is taken
        req    <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            check_flag("busy", busy, 1'b1);
        end while (!done);
        got = rdata; // sampled in the done cycle
        if (is_hit && waited != 1) begin
            stop_with_failure($sformatf("entry %0d: hit took %0d cycles", i, waited));
        end
        seen = (log_we.size() == 0) ? EXP_HIT : ((log_we.size() == 1) ? EXP_MISS : EXP_DIRTY);
        if (tbl_exp[i] != EXP_ANY && tbl_exp[i] != seen) begin
            stop_with_failure($sformatf("entry %0d: table expects kind %0d, cache gave %0d",
                                        i, tbl_exp[i], seen));
        end
        if (log_we.size() != n_exp) begin
            stop_with_failure($sformatf("entry %0d: expected %0d memory requests, saw %0d",
                                        i, n_exp, log_we.size()));
        end
        if (wb) begin
            if (log_we[0] !== 1'b1 || log_we[1] !== 1'b0) begin
                stop_with_failure("dirty eviction did not write back before the refill");
            end
            check_addr("mem_addr", log_addr[0], {ref_tag[idx][way], idx});
            check_line("mem_wd", log_data[0], ref_line[idx][way]);
            check_addr("mem_addr", log_addr[1], {tg, idx});
        end else if (!is_hit) begin
            if (log_we[0] !== 1'b0) begin
                stop_with_failure("refill was issued as a memory write");
            end
            check_addr("mem_addr", log_addr[0], {tg, idx});
        end
        if (!is_hit) begin
            ref_line[idx][way]  = read_mem({tg, idx});
            ref_valid[idx][way] = 1'b1;
            ref_dirty[idx][way] = 1'b0;
            ref_tag[idx][way]   = tg;
        end
        if (tbl_we[i]) begin
            ref_line[idx][way][int'(ws)*`L2_WORD_W +: `L2_WORD_W] = tbl_wdata[i];
            ref_dirty[idx][way] = 1'b1;
        end else begin
            check_word("rdata", got, ref_line[idx][way][int'(ws)*`L2_WORD_W +: `L2_WORD_W]);
        end
        touch_tree(idx, way);
    endtask

    // line memory answering 1 to 4 cycles after each request
    always @(posedge clk) begin
        mem_ack <= 1'b0;
        if (rst) begin
            mem_pending = 1'b0;
        end else begin
            if (mem_req) begin
                if (mem_pending) begin
                    stop_with_failure("memory request while another one is outstanding");
                end
                log_we.push_back(mem_we);
                log_addr.push_back(mem_addr);
                log_data.push_back(mem_wd);
                if (mem_we) begin
                    mem_store[mem_addr] = mem_wd;
                end
                mem_pending   = 1'b1;
                mem_pend_addr = mem_addr;
                mem_wait      = int'($unsigned($random(seed)) % 4);
            end
            if (mem_pending) begin
                if (mem_wait == 0) begin
                    mem_ack     <= 1'b1;
                    mem_rd      <= read_mem(mem_pend_addr);
                    mem_pending = 1'b0;
                end else begin
                    mem_wait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        logic [31:0] r;
        clk         = 1'b0;
        rst         = 1'b1;
        req         = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        mem_ack     = 1'b0;
        mem_rd      = '0;
        mem_pending = 1'b0;
        mem_wait    = 0;
        cycle_count = 0;
        seed        = 78;
        n_fill      = 0;
        for (int s = 0; s < SETS; s++) begin
            ref_tree[s] = 3'b000;
            for (int w = 0; w < `L2_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
                ref_line[s][w]  = '0;
            end
        end
        add_entry(1'b0, 17'h1, SET_A, 2'd0, '0, EXP_MISS);      // cold read
        add_entry(1'b0, 17'h1, SET_A, 2'd0, '0, EXP_HIT);
        add_entry(1'b1, 17'h1, SET_A, 2'd2, WORD_X, EXP_HIT);   // write hit merge
        add_entry(1'b0, 17'h1, SET_A, 2'd2, '0, EXP_HIT);
        add_entry(1'b0, 17'h1, SET_A, 2'd1, '0, EXP_HIT);
        add_entry(1'b0, 17'h1, SET_A, 2'd3, '0, EXP_HIT);
        add_entry(1'b0, 17'h1, SET_A, 2'd0, '0, EXP_HIT);
        add_entry(1'b0, 17'h10, SET_B, 2'd0, '0, EXP_MISS);     // ways 0 to 3 fill
        add_entry(1'b0, 17'h11, SET_B, 2'd1, '0, EXP_MISS);
        add_entry(1'b0, 17'h12, SET_B, 2'd2, '0, EXP_MISS);
        add_entry(1'b0, 17'h13, SET_B, 2'd3, '0, EXP_MISS);
        add_entry(1'b0, 17'h14, SET_B, 2'd0, '0, EXP_MISS);     // tree evicts way 0
        add_entry(1'b0, 17'h11, SET_B, 2'd1, '0, EXP_HIT);
        add_entry(1'b0, 17'h10, SET_B, 2'd0, '0, EXP_MISS);     // evicted line comes back
        add_entry(1'b0, 17'h2, SET_A, 2'd0, '0, EXP_MISS);
        add_entry(1'b0, 17'h3, SET_A, 2'd0, '0, EXP_MISS);
        add_entry(1'b0, 17'h4, SET_A, 2'd0, '0, EXP_MISS);
        add_entry(1'b0, 17'h5, SET_A, 2'd0, '0, EXP_DIRTY);     // dirty way 0 goes out
        add_entry(1'b0, 17'h1, SET_A, 2'd2, '0, EXP_MISS);      // merged word from memory
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            add_entry(r[0], l2_cache_pkg::tag_t'(r[6:4]) + 17'd1, r[8] ? SET_B : SET_A,
                      r[11:10], {$random(seed), $random(seed), $random(seed), $random(seed)},
                      EXP_ANY);
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < N_ENTRIES; i++) begin
            run_entry(i);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/l2_cache_pkg.sv
logic/l2_set_ram.sv
logic/l2_tag_lookup.sv
logic/l2_replace.sv
logic/l2_cache_ctrl.sv
logic/l2_cache.sv
tests/l2_cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the L2 cache testbench with Verilator and runs it.
# The exit status is the simulator's, so a failing run returns non-zero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module l2_cache_tb -o l2_cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/l2_cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi
exit $status
